// ==== include/csr_consts.svh ====
// Machine CSR constants (addresses, write masks, reset values, bit positions), include where needed
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Machine CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344
`define CSR_CYCLE     12'hC00
`define CSR_CYCLEH    12'hC80
`define CSR_MHARTID   12'hF14

// Write masks, any CSR not listed takes a full mask
`define MSTATUS_WMASK 32'h807F_F9BB
`define MIE_WMASK     32'h0000_0888
`define MTVEC_WMASK   32'hFFFF_FFFD
`define MEPC_WMASK    32'hFFFF_FFFC
`define MIP_WMASK     32'h0000_0008

// Reset values
`define MSTATUS_RST   32'h0000_1880
`define MTVEC_RST     32'h0000_1000

// Constant reads, RV32I with MXL = 1
`define MISA_VAL      32'h4000_0100
`define HART_ID       32'h0000_0000

// mstatus bits
`define MST_MIE       3
`define MST_MPIE      7

// mie and mip bits
`define MIE_MSIP      3
`define MIE_MTIP      7
`define MIE_MEIP      11

// Packed enable group from the register file to the arbiter
`define STS_GIE       0
`define STS_MSIE      1
`define STS_MTIE      2
`define STS_MEIE      3

// Vectored mode handler offsets from the mtvec base
`define VEC_OFS_SW    32'h0000_000C
`define VEC_OFS_TIMER 32'h0000_001C
`define VEC_OFS_EXT   32'h0000_002C

`endif

// ==== hw/csr_pkg.sv ====
// Shared types for the CSR unit: opcodes, mcause codes, request, interrupt, event and trap structs
package csr_pkg;

  // Zicsr opcodes, encoded as funct3 so the decoder can pass it through
  typedef enum logic [2:0] {
    CSR_NONE = 3'b000,
    CSR_RW   = 3'b001,
    CSR_RS   = 3'b010,
    CSR_RC   = 3'b011,
    CSR_RWI  = 3'b101,
    CSR_RSI  = 3'b110,
    CSR_RCI  = 3'b111
  } csr_op_e;

  // mcause codes, top bit marks an interrupt
  typedef enum logic [31:0] {
    INSTR_MISALIGNED = 32'd0,
    FETCH_FAULT      = 32'd1,
    ILLEGAL          = 32'd2,
    BREAKPOINT       = 32'd3,
    LOAD_MISALIGNED  = 32'd4,
    LOAD_FAULT       = 32'd5,
    STORE_MISALIGNED = 32'd6,
    STORE_FAULT      = 32'd7,
    ECALL_M          = 32'd11,
    M_SW_INT         = 32'h8000_0003,
    M_TIMER_INT      = 32'h8000_0007,
    M_EXT_INT        = 32'h8000_000B
  } cause_e;

  // CSR access from the execute stage
  typedef struct packed {
    csr_op_e     op;
    logic [11:0] addr;
    logic        rs1_is_x0;
    logic [31:0] rs1;
    logic [31:0] imm;
  } csr_req_t;

  // Level-sensitive interrupt lines
  typedef struct packed {
    logic ext;
    logic sw;
    logic timer;
  } irq_t;

  // Exception and return events, one-cycle pulses
  typedef struct packed {
    logic        fetch_fault;
    logic        illegal;
    logic        instr_mis;
    logic        ecall;
    logic        ebreak;
    logic        mret;
    logic        ld_mis;
    logic        ld_fault;
    logic        st_mis;
    logic        st_fault;
    logic [31:0] pc;
    logic [31:0] lsu_pc;
    logic [31:0] mtval;
  } trap_evt_t;

  // Winning trap, arbiter to register file
  typedef struct packed {
    logic        take;
    logic        is_mret;
    logic        is_int;
    cause_e      cause;
    logic [31:0] epc;
    logic [31:0] tval;
  } trap_sel_t;

  // Redirect to the fetch stage
  typedef struct packed {
    logic        active;
    logic [31:0] pc;
  } trap_t;

endpackage

// ==== hw/trap_arbiter.sv ====
// Combinational trap priority decoder, picks one interrupt or exception per cycle for csr_file
`include "csr_consts.svh"

module trap_arbiter (
  input  csr_pkg::irq_t      irq_i,
  input  csr_pkg::trap_evt_t evt_i,
  input  logic [3:0]         status_i,
  output csr_pkg::trap_sel_t sel_o
);

  logic int_ext;
  logic int_sw;
  logic int_timer;

  // Builds a normal trap record, interrupts are recognized by the cause top bit
  function automatic csr_pkg::trap_sel_t pick(
    csr_pkg::cause_e cause,
    logic [31:0]     epc,
    logic [31:0]     tval
  );
    csr_pkg::trap_sel_t t;
    t.take    = 1'b1;
    t.is_mret = 1'b0;
    t.is_int  = cause[31];
    t.cause   = cause;
    t.epc     = epc;
    t.tval    = tval;
    return t;
  endfunction

  // Interrupt needs both the global enable and its own enable
  assign int_ext   = irq_i.ext   && status_i[`STS_GIE] && status_i[`STS_MEIE];
  assign int_sw    = irq_i.sw    && status_i[`STS_GIE] && status_i[`STS_MSIE];
  assign int_timer = irq_i.timer && status_i[`STS_GIE] && status_i[`STS_MTIE];

  always_comb begin
    sel_o = '0;

    if (int_ext) begin
      sel_o = pick(csr_pkg::M_EXT_INT, evt_i.pc, 32'h0);
    end else if (int_sw) begin
      sel_o = pick(csr_pkg::M_SW_INT, evt_i.pc, 32'h0);
    end else if (int_timer) begin
      sel_o = pick(csr_pkg::M_TIMER_INT, evt_i.pc, 32'h0);
    end

    // Synchronous exceptions from the front end and decode
    else if (evt_i.fetch_fault) begin
      sel_o = pick(csr_pkg::FETCH_FAULT, evt_i.pc, evt_i.mtval);
    end else if (evt_i.illegal) begin
      sel_o = pick(csr_pkg::ILLEGAL, evt_i.pc, evt_i.mtval);
    end else if (evt_i.instr_mis) begin
      sel_o = pick(csr_pkg::INSTR_MISALIGNED, evt_i.pc, evt_i.mtval);
    end else if (evt_i.ecall) begin
      sel_o = pick(csr_pkg::ECALL_M, evt_i.pc, 32'h0);
    end else if (evt_i.ebreak) begin
      sel_o = pick(csr_pkg::BREAKPOINT, evt_i.pc, 32'h0);
    end

    // Return is handled as a trap without cause, epc or tval
    else if (evt_i.mret) begin
      sel_o.take    = 1'b1;
      sel_o.is_mret = 1'b1;
    end

    // Load and store faults report the LSU address in both epc and tval
    else if (evt_i.ld_mis) begin
      sel_o = pick(csr_pkg::LOAD_MISALIGNED, evt_i.lsu_pc, evt_i.lsu_pc);
    end else if (evt_i.ld_fault) begin
      sel_o = pick(csr_pkg::LOAD_FAULT, evt_i.lsu_pc, evt_i.lsu_pc);
    end else if (evt_i.st_mis) begin
      sel_o = pick(csr_pkg::STORE_MISALIGNED, evt_i.lsu_pc, evt_i.lsu_pc);
    end else if (evt_i.st_fault) begin
      sel_o = pick(csr_pkg::STORE_FAULT, evt_i.lsu_pc, evt_i.lsu_pc);
    end
  end

endmodule

// ==== hw/csr_file.sv ====
// Machine CSR storage with read-modify-write, cycle counter, trap commit and registered redirect
`include "csr_consts.svh"

module csr_file #(
  parameter logic [31:0] MTVEC_RESET_VAL = `MTVEC_RST
) (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               stall_i,
  input  csr_pkg::csr_req_t  csr_req_i,
  input  csr_pkg::irq_t      irq_i,
  input  csr_pkg::trap_sel_t sel_i,
  output logic [31:0]        csr_rd_o,
  output logic [3:0]         status_o,
  output csr_pkg::trap_t     trap_o
);

  logic [31:0] mstatus_q, mstatus_d;
  logic [31:0] mie_q, mie_d;
  logic [31:0] mtvec_q, mtvec_d;
  logic [31:0] mscratch_q, mscratch_d;
  logic [31:0] mepc_q, mepc_d;
  logic [31:0] mcause_q, mcause_d;
  logic [31:0] mtval_q, mtval_d;
  logic [31:0] mip_q, mip_d;
  logic [63:0] cycle_q;

  logic [31:0] wmask;
  logic [31:0] wdata;
  logic [31:0] vec_ofs;

  csr_pkg::trap_t trap_q, trap_d;

  // Applies the op, the x0 rule, the stall and the write mask
  function automatic logic [31:0] rmw(
    csr_pkg::csr_req_t req,
    logic [31:0]       cur,
    logic [31:0]       mask,
    logic              stall
  );
    logic [31:0] res;
    logic        set_clr;
    logic        wr_en;
    set_clr = (req.op == csr_pkg::CSR_RS)  || (req.op == csr_pkg::CSR_RC) ||
              (req.op == csr_pkg::CSR_RSI) || (req.op == csr_pkg::CSR_RCI);
    case (req.op)
      csr_pkg::CSR_RW:  res = req.rs1;
      csr_pkg::CSR_RS:  res = cur | req.rs1;
      csr_pkg::CSR_RC:  res = cur & ~req.rs1;
      csr_pkg::CSR_RWI: res = req.imm;
      csr_pkg::CSR_RSI: res = cur | req.imm;
      csr_pkg::CSR_RCI: res = cur & ~req.imm;
      default:          res = cur;
    endcase
    wr_en = !stall && (req.op != csr_pkg::CSR_NONE) && !(set_clr && req.rs1_is_x0);
    return wr_en ? (res & mask) : cur;
  endfunction

  // Read mux, zero latency
  always_comb begin
    csr_rd_o = 32'h0;
    wmask    = 32'hFFFF_FFFF;
    case (csr_req_i.addr)
      `CSR_MSTATUS: begin
        csr_rd_o = mstatus_q;
        wmask    = `MSTATUS_WMASK;
      end
      `CSR_MIE: begin
        csr_rd_o = mie_q;
        wmask    = `MIE_WMASK;
      end
      `CSR_MTVEC: begin
        csr_rd_o = mtvec_q;
        wmask    = `MTVEC_WMASK;
      end
      `CSR_MEPC: begin
        csr_rd_o = mepc_q;
        wmask    = `MEPC_WMASK;
      end
      `CSR_MIP: begin
        csr_rd_o = mip_q;
        wmask    = `MIP_WMASK;
      end
      `CSR_MSCRATCH: csr_rd_o = mscratch_q;
      `CSR_MCAUSE:   csr_rd_o = mcause_q;
      `CSR_MTVAL:    csr_rd_o = mtval_q;
      `CSR_CYCLE:    csr_rd_o = cycle_q[31:0];
      `CSR_CYCLEH:   csr_rd_o = cycle_q[63:32];
      `CSR_MISA:     csr_rd_o = `MISA_VAL;
      `CSR_MHARTID:  csr_rd_o = `HART_ID;
      default:       csr_rd_o = 32'h0;
    endcase
  end

  assign wdata = rmw(csr_req_i, csr_rd_o, wmask, stall_i);

  // Next state, CSR write first so a trap below can override it
  always_comb begin
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mtvec_d    = mtvec_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    mip_d      = mip_q;

    case (csr_req_i.addr)
      `CSR_MSTATUS:  mstatus_d  = wdata;
      `CSR_MIE:      mie_d      = wdata;
      `CSR_MTVEC:    mtvec_d    = wdata;
      `CSR_MSCRATCH: mscratch_d = wdata;
      `CSR_MEPC:     mepc_d     = wdata;
      `CSR_MTVAL:    mtval_d    = wdata;
      `CSR_MIP:      mip_d      = wdata;
      default:       ;
    endcase

    // Timer and external pending bits mirror the lines
    mip_d[`MIE_MTIP] = irq_i.timer;
    mip_d[`MIE_MEIP] = irq_i.ext;

    if (sel_i.take && sel_i.is_mret) begin
      mstatus_d[`MST_MIE]  = mstatus_q[`MST_MPIE];
      mstatus_d[`MST_MPIE] = 1'b1;
    end else if (sel_i.take) begin
      mepc_d               = sel_i.epc;
      mcause_d             = sel_i.cause;
      mtval_d              = sel_i.tval;
      mstatus_d[`MST_MPIE] = mstatus_q[`MST_MIE];
      mstatus_d[`MST_MIE]  = 1'b0;
    end
  end

  // Handler offset only for interrupts in vectored mode
  always_comb begin
    vec_ofs = 32'h0;
    if (mtvec_q[0] && sel_i.is_int) begin
      case (sel_i.cause)
        csr_pkg::M_SW_INT:    vec_ofs = `VEC_OFS_SW;
        csr_pkg::M_TIMER_INT: vec_ofs = `VEC_OFS_TIMER;
        csr_pkg::M_EXT_INT:   vec_ofs = `VEC_OFS_EXT;
        default:              vec_ofs = 32'h0;
      endcase
    end
  end

  assign trap_d.active = sel_i.take;
  assign trap_d.pc     = sel_i.is_mret ? mepc_q : ({mtvec_q[31:2], 2'b00} + vec_ofs);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mstatus_q  <= `MSTATUS_RST;
      mie_q      <= 32'h0;
      mtvec_q    <= MTVEC_RESET_VAL;
      mscratch_q <= 32'h0;
      mepc_q     <= 32'h0;
      mcause_q   <= 32'h0;
      mtval_q    <= 32'h0;
      mip_q      <= 32'h0;
      cycle_q    <= 64'h0;
      trap_q     <= '0;
    end else begin
      mstatus_q  <= mstatus_d;
      mie_q      <= mie_d;
      mtvec_q    <= mtvec_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
      mip_q      <= mip_d;
      cycle_q    <= cycle_q + 64'd1;
      trap_q     <= trap_d;
    end
  end

  // Enable group for the arbiter
  assign status_o[`STS_GIE]  = mstatus_q[`MST_MIE];
  assign status_o[`STS_MSIE] = mie_q[`MIE_MSIP];
  assign status_o[`STS_MTIE] = mie_q[`MIE_MTIP];
  assign status_o[`STS_MEIE] = mie_q[`MIE_MEIP];

  assign trap_o = trap_q;

endmodule

// ==== hw/csr_unit.sv ====
// CSR unit top level, joins the trap arbiter to the machine CSR file
`include "csr_consts.svh"

module csr_unit #(
  parameter logic [31:0] MTVEC_RESET_VAL = `MTVEC_RST
) (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               stall_i,
  input  csr_pkg::csr_req_t  csr_req_i,
  input  csr_pkg::irq_t      irq_i,
  input  csr_pkg::trap_evt_t evt_i,
  output logic [31:0]        csr_rd_o,
  output csr_pkg::trap_t     trap_o
);

  // Global and per-source interrupt enables
  logic [3:0]         status;
  csr_pkg::trap_sel_t sel;

  // Picks the winning interrupt or exception this cycle
  trap_arbiter u_trap_arbiter (
    .irq_i    (irq_i),
    .evt_i    (evt_i),
    .status_i (status),
    .sel_o    (sel)
  );

  // Commits the trap and registers the redirect
  csr_file #(
    .MTVEC_RESET_VAL (MTVEC_RESET_VAL)
  ) u_csr_file (
    .clk       (clk),
    .rst_i     (rst_i),
    .stall_i   (stall_i),
    .csr_req_i (csr_req_i),
    .irq_i     (irq_i),
    .sel_i     (sel),
    .csr_rd_o  (csr_rd_o),
    .status_o  (status),
    .trap_o    (trap_o)
  );

endmodule

// ==== tb/csr_unit_tb.sv ====
// Table-driven testbench for csr_unit, builds steps from a CSR reference model and applies them
`include "csr_consts.svh"

module csr_unit_tb;

  localparam logic [1:0] K_CSR  = 2'd0;
  localparam logic [1:0] K_EVT  = 2'd1;
  localparam logic [1:0] K_IDLE = 2'd2;
  localparam logic [1:0] K_CYC  = 2'd3;
  localparam int MAX_STEPS = 128;
  localparam int TIMEOUT   = 20;

  // One row of the stimulus table
  typedef struct packed {
    logic [1:0]         kind;
    csr_pkg::csr_req_t  req;
    csr_pkg::irq_t      irq;
    csr_pkg::trap_evt_t evt;
    logic               stall;
    logic [31:0]        exp_rd;
    logic               exp_take;
    csr_pkg::trap_t     exp_trap;
  } step_t;

  logic               clk;
  logic               rst_i;
  logic               stall_i;
  csr_pkg::csr_req_t  csr_req_i;
  csr_pkg::irq_t      irq_i;
  csr_pkg::trap_evt_t evt_i;
  logic [31:0]        csr_rd_o;
  csr_pkg::trap_t     trap_o;

  step_t steps [MAX_STEPS];
  string names [MAX_STEPS];
  int    n_steps;
  int    errors;
  int    failed_tests;
  integer seed;
  longint unsigned cyc_cnt = 0;
  longint unsigned last_cnt;
  logic [31:0]     last_rd;
  logic            have_cyc;

  csr_pkg::csr_op_e op_list [6] = '{csr_pkg::CSR_RW, csr_pkg::CSR_RS, csr_pkg::CSR_RC,
                                    csr_pkg::CSR_RWI, csr_pkg::CSR_RSI, csr_pkg::CSR_RCI};

  // Reference model of the machine CSRs
  logic [31:0]   m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
  csr_pkg::irq_t m_irq;

  csr_unit dut (
    .clk       (clk),
    .rst_i     (rst_i),
    .stall_i   (stall_i),
    .csr_req_i (csr_req_i),
    .irq_i     (irq_i),
    .evt_i     (evt_i),
    .csr_rd_o  (csr_rd_o),
    .trap_o    (trap_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

  function automatic logic [31:0] model_mask(logic [11:0] addr);
    case (addr)
      `CSR_MSTATUS: return `MSTATUS_WMASK;
      `CSR_MIE:     return `MIE_WMASK;
      `CSR_MTVEC:   return `MTVEC_WMASK;
      `CSR_MEPC:    return `MEPC_WMASK;
      default:      return 32'hFFFF_FFFF;
    endcase
  endfunction

  function automatic logic [31:0] model_read(logic [11:0] addr);
    case (addr)
      `CSR_MSTATUS:  return m_mstatus;
      `CSR_MISA:     return `MISA_VAL;
      `CSR_MIE:      return m_mie;
      `CSR_MTVEC:    return m_mtvec;
      `CSR_MSCRATCH: return m_mscratch;
      `CSR_MEPC:     return m_mepc;
      `CSR_MCAUSE:   return m_mcause;
      `CSR_MTVAL:    return m_mtval;
      `CSR_MIP:      return {20'h0, m_irq.ext, 3'h0, m_irq.timer, 7'h0};
      `CSR_MHARTID:  return `HART_ID;
      default:       return 32'h0;
    endcase
  endfunction

  // mcause and the constants take no writes
  task automatic model_write(logic [11:0] addr, logic [31:0] val);
    case (addr)
      `CSR_MSTATUS:  m_mstatus  = val;
      `CSR_MIE:      m_mie      = val;
      `CSR_MTVEC:    m_mtvec    = val;
      `CSR_MSCRATCH: m_mscratch = val;
      `CSR_MEPC:     m_mepc     = val;
      `CSR_MTVAL:    m_mtval    = val;
      default:       ;
    endcase
  endtask

  task automatic model_trap(csr_pkg::cause_e cause, logic [31:0] epc, logic [31:0] tval,
                            output logic [31:0] target);
    logic [31:0] ofs;
    ofs = 32'h0;
    if (m_mtvec[0] && cause[31]) begin
      if (cause == csr_pkg::M_SW_INT)
        ofs = `VEC_OFS_SW;
      else if (cause == csr_pkg::M_TIMER_INT)
        ofs = `VEC_OFS_TIMER;
      else
        ofs = `VEC_OFS_EXT;
    end
    target = {m_mtvec[31:2], 2'b00} + ofs;
    m_mepc = epc;
    m_mcause = cause;
    m_mtval = tval;
    m_mstatus[`MST_MPIE] = m_mstatus[`MST_MIE];
    m_mstatus[`MST_MIE] = 1'b0;
  endtask

  task automatic push(string name, step_t s);
    if (n_steps < MAX_STEPS) begin
      names[n_steps] = name;
      steps[n_steps] = s;
      n_steps++;
    end
  endtask

  // CSR access row, expects the old value and updates the model
  task automatic add_csr(string name, csr_pkg::csr_op_e op, logic [11:0] addr,
                         logic [31:0] opnd, logic x0, logic stall);
    step_t       s;
    logic [31:0] old;
    logic [31:0] nv;
    logic        imm_form;
    logic        set_clr;
    s = '0;
    old = model_read(addr);
    imm_form = (op == csr_pkg::CSR_RWI) || (op == csr_pkg::CSR_RSI) || (op == csr_pkg::CSR_RCI);
    set_clr = (op != csr_pkg::CSR_RW) && (op != csr_pkg::CSR_RWI) && (op != csr_pkg::CSR_NONE);
    s.kind = K_CSR;
    s.req.op = op;
    s.req.addr = addr;
    s.req.rs1_is_x0 = x0;
    // The unused operand carries the inverse to catch a wrong source
    s.req.rs1 = imm_form ? ~opnd : opnd;
    s.req.imm = imm_form ? opnd : ~opnd;
    s.irq = m_irq;
    s.stall = stall;
    s.exp_rd = old;
    case (op)
      csr_pkg::CSR_RW, csr_pkg::CSR_RWI: nv = opnd;
      csr_pkg::CSR_RS, csr_pkg::CSR_RSI: nv = old | opnd;
      csr_pkg::CSR_RC, csr_pkg::CSR_RCI: nv = old & ~opnd;
      default:                           nv = old;
    endcase
    if (!stall && op != csr_pkg::CSR_NONE && !(x0 && set_clr))
      model_write(addr, nv & model_mask(addr));
    push(name, s);
  endtask

  task automatic add_evt(string name, csr_pkg::trap_evt_t evt, csr_pkg::irq_t irq, logic take,
                         csr_pkg::cause_e cause, logic [31:0] epc, logic [31:0] tval);
    step_t       s;
    logic [31:0] tgt;
    s = '0;
    s.kind = K_EVT;
    s.evt = evt;
    s.irq = irq;
    m_irq = irq;
    s.exp_take = take;
    s.exp_trap.active = take;
    if (take && evt.mret) begin
      s.exp_trap.pc = m_mepc;
      m_mstatus[`MST_MIE] = m_mstatus[`MST_MPIE];
      m_mstatus[`MST_MPIE] = 1'b1;
    end else if (take) begin
      model_trap(cause, epc, tval, tgt);
      s.exp_trap.pc = tgt;
    end
    push(name, s);
  endtask

  task automatic add_plain(string name, logic [1:0] kind);
    step_t s;
    s = '0;
    s.kind = kind;
    s.req.addr = `CSR_CYCLE;
    s.irq = m_irq;
    push(name, s);
  endtask

  task automatic add_trap_reads(string tag);
    add_csr({tag, " mcause"}, csr_pkg::CSR_NONE, `CSR_MCAUSE, 32'h0, 1'b0, 1'b0);
    add_csr({tag, " mepc"}, csr_pkg::CSR_NONE, `CSR_MEPC, 32'h0, 1'b0, 1'b0);
    add_csr({tag, " mtval"}, csr_pkg::CSR_NONE, `CSR_MTVAL, 32'h0, 1'b0, 1'b0);
    add_csr({tag, " mstatus"}, csr_pkg::CSR_NONE, `CSR_MSTATUS, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic build_table();
    logic [11:0]        regs [4];
    logic [31:0]        v;
    csr_pkg::trap_evt_t e;
    csr_pkg::irq_t      q;
    regs[0] = `CSR_MSCRATCH;
    regs[1] = `CSR_MIE;
    regs[2] = `CSR_MTVEC;
    regs[3] = `CSR_MEPC;
    for (int r = 0; r < 4; r++) begin
      for (int o = 0; o < 6; o++) begin
        v = $random(seed);
        if (o >= 3)
          v = v & 32'h1F;
        add_csr($sformatf("%s on %h", op_list[o].name(), regs[r]), op_list[o], regs[r], v,
                1'b0, 1'b0);
      end
      add_csr("set with x0", csr_pkg::CSR_RS, regs[r], 32'hFFFF_FFFF, 1'b1, 1'b0);
      add_csr("clear imm with x0", csr_pkg::CSR_RCI, regs[r], 32'h1F, 1'b1, 1'b0);
      add_csr("read back", csr_pkg::CSR_NONE, regs[r], 32'h0, 1'b0, 1'b0);
    end
    add_csr("mcause write", csr_pkg::CSR_RW, `CSR_MCAUSE, 32'h1234_5678, 1'b0, 1'b0);
    add_csr("mcause unchanged", csr_pkg::CSR_NONE, `CSR_MCAUSE, 32'h0, 1'b0, 1'b0);
    add_csr("misa", csr_pkg::CSR_NONE, `CSR_MISA, 32'h0, 1'b0, 1'b0);
    add_csr("mhartid", csr_pkg::CSR_NONE, `CSR_MHARTID, 32'h0, 1'b0, 1'b0);
    add_csr("unknown address", csr_pkg::CSR_NONE, 12'h7C0, 32'h0, 1'b0, 1'b0);
    add_plain("cycle first", K_CYC);
    for (int k = 0; k < 5; k++)
      add_plain("idle", K_IDLE);
    add_plain("cycle delta", K_CYC);
    add_csr("stalled write", csr_pkg::CSR_RW, `CSR_MSCRATCH, 32'hDEAD_BEEF, 1'b0, 1'b1);
    add_csr("after stall", csr_pkg::CSR_NONE, `CSR_MSCRATCH, 32'h0, 1'b0, 1'b0);

    // Exceptions in direct mode, the first one with MIE set
    add_csr("mtvec direct", csr_pkg::CSR_RW, `CSR_MTVEC, 32'h0000_2000, 1'b0, 1'b0);
    add_csr("set MIE", csr_pkg::CSR_RSI, `CSR_MSTATUS, 32'h8, 1'b0, 1'b0);
    e = '0;
    e.ecall = 1'b1;
    e.pc = 32'h0000_0400;
    add_evt("ecall", e, '0, 1'b1, csr_pkg::ECALL_M, e.pc, 32'h0);
    add_trap_reads("ecall");
    e = '0;
    e.illegal = 1'b1;
    e.pc = 32'h0000_0480;
    e.mtval = 32'h0000_FFFF;
    add_evt("illegal", e, '0, 1'b1, csr_pkg::ILLEGAL, e.pc, e.mtval);
    add_trap_reads("illegal");
    e = '0;
    e.ld_fault = 1'b1;
    e.pc = 32'h0000_0500;
    e.lsu_pc = 32'h0000_0A13;
    add_evt("load fault", e, '0, 1'b1, csr_pkg::LOAD_FAULT, e.lsu_pc, e.lsu_pc);
    add_trap_reads("load fault");

    // Vectored interrupts, external wins over timer
    add_csr("set MIE", csr_pkg::CSR_RSI, `CSR_MSTATUS, 32'h8, 1'b0, 1'b0);
    add_csr("enable all mie", csr_pkg::CSR_RW, `CSR_MIE, 32'h888, 1'b0, 1'b0);
    add_csr("mtvec vectored", csr_pkg::CSR_RW, `CSR_MTVEC, 32'h0000_3001, 1'b0, 1'b0);
    q = '0;
    q.ext = 1'b1;
    q.timer = 1'b1;
    e = '0;
    e.pc = 32'h0000_0600;
    add_evt("ext and timer", e, q, 1'b1, csr_pkg::M_EXT_INT, e.pc, 32'h0);
    add_trap_reads("interrupt");
    e = '0;
    e.mret = 1'b1;
    add_evt("mret", e, '0, 1'b1, csr_pkg::ECALL_M, 32'h0, 32'h0);
    add_csr("mstatus after mret", csr_pkg::CSR_NONE, `CSR_MSTATUS, 32'h0, 1'b0, 1'b0);

    // Pending but disabled timer line
    add_csr("clear mie", csr_pkg::CSR_RW, `CSR_MIE, 32'h0, 1'b0, 1'b0);
    q = '0;
    q.timer = 1'b1;
    add_evt("masked timer", '0, q, 1'b0, csr_pkg::M_TIMER_INT, 32'h0, 32'h0);
    add_csr("mip pending", csr_pkg::CSR_NONE, `CSR_MIP, 32'h0, 1'b0, 1'b0);

    // Return with MPIE clear sets MPIE and drops MIE
    add_csr("clear MPIE", csr_pkg::CSR_RC, `CSR_MSTATUS, 32'h80, 1'b0, 1'b0);
    e = '0;
    e.mret = 1'b1;
    add_evt("mret with MPIE clear", e, '0, 1'b1, csr_pkg::ECALL_M, 32'h0, 32'h0);
    add_csr("mstatus after second mret", csr_pkg::CSR_NONE, `CSR_MSTATUS, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_trap(string what, csr_pkg::trap_t got, csr_pkg::trap_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s trap active %b pc %h, expected active %b pc %h",
               $time, what, got.active, got.pc, exp.active, exp.pc);
      errors++;
    end
  endtask

  task automatic run_step(int i);
    step_t s;
    int    errs_before;
    int    n;
    logic  seen;
    s = steps[i];
    errs_before = errors;
    @(posedge clk);
    #1;
    csr_req_i = s.req;
    irq_i = s.irq;
    evt_i = s.evt;
    stall_i = s.stall;
    case (s.kind)
      K_CSR: begin
        @(negedge clk);
        check_word(names[i], csr_rd_o, s.exp_rd);
      end
      K_CYC: begin
        @(negedge clk);
        if (have_cyc)
          check_word(names[i], csr_rd_o - last_rd, 32'(cyc_cnt - last_cnt));
        last_rd = csr_rd_o;
        last_cnt = cyc_cnt;
        have_cyc = 1'b1;
      end
      K_EVT: begin
        @(posedge clk);
        #1;
        evt_i = '0;
        seen = 1'b0;
        n = 0;
        while (!seen && n < TIMEOUT) begin
          @(negedge clk);
          if (trap_o.active)
            seen = 1'b1;
          else
            n++;
        end
        if (s.exp_take && !seen) begin
          $display("Error at %0t: %s, trap never asserted", $time, names[i]);
          errors++;
        end else if (!s.exp_take && seen) begin
          $display("Error at %0t: %s, trap taken while it is disabled", $time, names[i]);
          errors++;
        end else if (seen) begin
          check_trap(names[i], trap_o, s.exp_trap);
          @(negedge clk);
          if (trap_o.active) begin
            $display("Error at %0t: %s, trap held for more than one cycle", $time, names[i]);
            errors++;
          end
        end
      end
      default: ;
    endcase
    if (errors == errs_before) begin
      $display("step %0d %s: ok", i, names[i]);
    end else begin
      $display("step %0d %s: failed", i, names[i]);
      failed_tests++;
    end
  endtask

  initial begin
    seed = 32'he35c;
    rst_i = 1'b1;
    stall_i = 1'b0;
    csr_req_i = '0;
    irq_i = '0;
    evt_i = '0;
    errors = 0;
    failed_tests = 0;
    n_steps = 0;
    have_cyc = 1'b0;
    m_mstatus = `MSTATUS_RST;
    m_mtvec = `MTVEC_RST;
    m_mie = 32'h0;
    m_mscratch = 32'h0;
    m_mepc = 32'h0;
    m_mcause = 32'h0;
    m_mtval = 32'h0;
    m_irq = '0;
    build_table();
    repeat (4) @(posedge clk);
    #1;
    rst_i = 1'b0;
    for (int i = 0; i < n_steps; i++)
      run_step(i);
    $display("%0d steps, %0d failed, %0d errors", n_steps, failed_tests, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== csr_unit.f ====
+incdir+include
hw/csr_pkg.sv
hw/trap_arbiter.sv
hw/csr_file.sv
hw/csr_unit.sv
tb/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CSR unit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f csr_unit.f --top-module csr_unit_tb -o csr_unit_sim

./obj_dir/csr_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
